/* files.f */
+incdir+rtl
rtl/axi_reg_pkg.sv
rtl/rd_rep_if.sv
rtl/axi_skid_buf.sv
rtl/tmr_rd_voter.sv
rtl/tmr_axi_reg_rd.sv
test/tb_tmr_axi_reg_rd.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the TMR AXI read slice testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

TOP=tb_tmr_axi_reg_rd
OBJ_DIR=obj_dir
LOG=sim.log
PASS_MSG="all tests passed"

verilator --binary --timing --assert -f files.f --top-module "$TOP" \
    -Mdir "$OBJ_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "ERROR: Verilator build did not complete"
    exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "ERROR: simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
    echo "RESULT: PASS"
    exit 0
fi

echo "RESULT: FAIL"
exit 1

/* test/tb_tmr_axi_reg_rd.sv */
//*********************************************************************
// Testbench for the TMR AXI read slice. Beats come from fixed tables;
// far-side ready is high, low or random per test. Outputs are
// sampled at the falling edge or 1 ns after the rising edge.
//*********************************************************************

`timescale 1ns/1ps

module tb_tmr_axi_reg_rd;
    import axi_reg_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int N_AR        = 8;
    localparam int N_R         = 8;
    // Pass-through, throughput and random runs plus three stall beats
    localparam int TOTAL_BEATS = 3 * N_AR + 3 * N_R + 3;
    localparam int LIMIT_CYC   = TOTAL_BEATS * 20 + 200;

    logic     clk = 1'b0;
    logic     rst_n = 1'b1;
    ar_beat_t s_ar = '0;
    logic     s_axi_arvalid = 1'b0;
    logic     s_axi_arready;
    r_beat_t  s_r;
    logic     s_axi_rvalid;
    logic     s_axi_rready = 1'b0;
    ar_beat_t m_ar;
    logic     m_axi_arvalid;
    logic     m_axi_arready = 1'b0;
    r_beat_t  m_r = '0;
    logic     m_axi_rvalid = 1'b0;
    logic     m_axi_rready;

    ar_beat_t ar_tab [N_AR];
    r_beat_t  r_tab [N_R];
    ar_beat_t ar_exp [$];
    r_beat_t  r_exp [$];
    int       ar_tq [$];
    int       r_tq [$];

    // Far-side ready is high in mode 0, low in mode 1 and random in mode 2
    int     ar_mode = 0;
    int     r_mode = 0;
    bit     lat_check = 1'b0;
    integer seed = 32'h4d196ccd;
    int     cyc = 0;
    int     ar_acc = 0;
    int     ar_out = 0;
    int     ar_done = 0;
    int     r_out = 0;
    int     r_done = 0;
    int     errors = 0;
    int     checks = 0;
    int     err_base = 0;
    int     tests_run = 0;
    int     tests_bad = 0;
    string  cur_test = "none";

    always #(CLK_PERIOD / 2) clk = ~clk;

    tmr_axi_reg_rd dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axi_arid    (s_ar.id),
        .s_axi_araddr  (s_ar.addr),
        .s_axi_arlen   (s_ar.len),
        .s_axi_arsize  (s_ar.size),
        .s_axi_arburst (s_ar.burst),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rid     (s_r.id),
        .s_axi_rdata   (s_r.data),
        .s_axi_rresp   (s_r.resp),
        .s_axi_rlast   (s_r.last),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .m_axi_arid    (m_ar.id),
        .m_axi_araddr  (m_ar.addr),
        .m_axi_arlen   (m_ar.len),
        .m_axi_arsize  (m_ar.size),
        .m_axi_arburst (m_ar.burst),
        .m_axi_arvalid (m_axi_arvalid),
        .m_axi_arready (m_axi_arready),
        .m_axi_rid     (m_r.id),
        .m_axi_rdata   (m_r.data),
        .m_axi_rresp   (m_r.resp),
        .m_axi_rlast   (m_r.last),
        .m_axi_rvalid  (m_axi_rvalid),
        .m_axi_rready  (m_axi_rready)
    );

    function automatic logic pick_ready(input int mode, input logic coin);
        if (mode == 0) begin
            return 1'b1;
        end
        if (mode == 1) begin
            return 1'b0;
        end
        return coin;
    endfunction

    task automatic check_eq(input string what, input logic [63:0] exp,
                            input logic [63:0] act);
        checks++;
        assert (exp === act) else begin
            $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            $display("Error in %s: %s", cur_test, msg);
            errors++;
        end
    endtask

    task automatic begin_test(input string name, input int am, input int rm,
                              input bit lat);
        @(negedge clk);
        cur_test  = name;
        ar_mode   = am;
        r_mode    = rm;
        lat_check = lat;
        err_base  = errors;
        @(posedge clk);
        #1;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_base) begin
            $display("test %-10s ok", cur_test);
        end else begin
            tests_bad++;
            $display("test %-10s %0d errors", cur_test, errors - err_base);
        end
    endtask

    // AXI master on the s side
    task automatic send_ar(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            s_ar          = ar_tab[i];
            s_axi_arvalid = 1'b1;
            do @(negedge clk); while (!s_axi_arready);
            @(posedge clk);
            #1;
        end
        s_axi_arvalid = 1'b0;
    endtask

    // AXI slave on the m side
    task automatic send_r(input int first, input int count);
        for (int i = first; i < first + count; i++) begin
            m_r          = r_tab[i];
            m_axi_rvalid = 1'b1;
            do @(negedge clk); while (!m_axi_rready);
            @(posedge clk);
            #1;
        end
        m_axi_rvalid = 1'b0;
    endtask

    task automatic wait_drain();
        do begin
            @(posedge clk);
            #1;
        end while (ar_exp.size() != 0 || r_exp.size() != 0);
    endtask

    // Far-side ready and cycle count
    initial begin : ready_drive
        int rnd;
        forever begin
            @(posedge clk);
            cyc++;
            #1;
            rnd           = $random(seed);
            m_axi_arready = pick_ready(ar_mode, rnd[0]);
            s_axi_rready  = pick_ready(r_mode, rnd[1]);
        end
    end

    // Handshakes are decided at the falling edge and data moves on the next rising edge
    initial begin : monitor
        ar_beat_t exp_ar;
        r_beat_t  exp_r;
        forever begin
            @(negedge clk);
            if (rst_n) begin
                if (m_axi_arvalid && m_axi_arready) begin
                    check_true(ar_exp.size() > 0, "AR beat came out that was never sent");
                    if (ar_exp.size() > 0) begin
                        exp_ar = ar_exp.pop_front();
                        check_eq("AR beat", 64'(exp_ar), 64'(m_ar));
                        if (lat_check) begin
                            check_eq("AR latency", 64'd1, 64'(cyc + 1 - ar_tq[0]));
                        end
                        void'(ar_tq.pop_front());
                    end
                    ar_out++;
                    ar_done = cyc + 1;
                end
                if (s_axi_arvalid && s_axi_arready) begin
                    ar_exp.push_back(s_ar);
                    ar_tq.push_back(cyc + 1);
                    ar_acc++;
                end
                if (s_axi_rvalid && s_axi_rready) begin
                    check_true(r_exp.size() > 0, "R beat came out that was never sent");
                    if (r_exp.size() > 0) begin
                        exp_r = r_exp.pop_front();
                        check_eq("R beat", 64'(exp_r), 64'(s_r));
                        if (lat_check) begin
                            check_eq("R latency", 64'd1, 64'(cyc + 1 - r_tq[0]));
                        end
                        void'(r_tq.pop_front());
                    end
                    r_out++;
                    r_done = cyc + 1;
                end
                if (m_axi_rvalid && m_axi_rready) begin
                    r_exp.push_back(m_r);
                    r_tq.push_back(cyc + 1);
                end
            end
        end
    end

    initial begin : watchdog
        #(LIMIT_CYC * CLK_PERIOD);
        $display("Timeout: handshakes did not finish within %0d cycles", LIMIT_CYC);
        $display("tests failed");
        $finish;
    end

    initial begin : main
        int base;
        int base_r;
        int start;

        ar_tab[0] = '{id: 4'h1, addr: 32'h0000_1000, len: 8'd0, size: 3'd2, burst: BURST_INCR};
        ar_tab[1] = '{id: 4'h2, addr: 32'h0000_2040, len: 8'd3, size: 3'd2, burst: BURST_INCR};
        ar_tab[2] = '{id: 4'hf, addr: 32'hffff_fffc, len: 8'd0, size: 3'd2, burst: BURST_FIXED};
        ar_tab[3] = '{id: 4'h0, addr: 32'h8000_0000, len: 8'd255, size: 3'd1, burst: BURST_INCR};
        ar_tab[4] = '{id: 4'h5, addr: 32'h1234_5678, len: 8'd7, size: 3'd0, burst: BURST_WRAP};
        ar_tab[5] = '{id: 4'ha, addr: 32'ha5a5_a5a4, len: 8'd15, size: 3'd2, burst: BURST_WRAP};
        ar_tab[6] = '{id: 4'h3, addr: 32'h0000_0004, len: 8'd1, size: 3'd1, burst: BURST_FIXED};
        ar_tab[7] = '{id: 4'hc, addr: 32'h5a5a_5a58, len: 8'd127, size: 3'd2, burst: BURST_INCR};
        r_tab[0]  = '{id: 4'h1, data: 32'hdead_beef, resp: RESP_OKAY, last: 1'b1};
        r_tab[1]  = '{id: 4'h2, data: 32'h0000_0000, resp: RESP_OKAY, last: 1'b0};
        r_tab[2]  = '{id: 4'h2, data: 32'hffff_ffff, resp: RESP_EXOKAY, last: 1'b0};
        r_tab[3]  = '{id: 4'h2, data: 32'h1234_5678, resp: RESP_SLVERR, last: 1'b1};
        r_tab[4]  = '{id: 4'hf, data: 32'ha5a5_a5a5, resp: RESP_DECERR, last: 1'b1};
        r_tab[5]  = '{id: 4'h5, data: 32'h0f0f_0f0f, resp: RESP_OKAY, last: 1'b0};
        r_tab[6]  = '{id: 4'h5, data: 32'hf0f0_f0f0, resp: RESP_SLVERR, last: 1'b0};
        r_tab[7]  = '{id: 4'h5, data: 32'h89ab_cdef, resp: RESP_OKAY, last: 1'b1};

        cur_test = "reset";
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #1;
            check_true(!m_axi_arvalid && !s_axi_rvalid, "valid high during reset");
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_true(!m_axi_arvalid && !s_axi_rvalid, "valid high after reset release");
        check_true(s_axi_arready && m_axi_rready, "ready not high after reset");
        end_test();

        begin_test("ar_pass", 0, 0, 1'b1);
        base = ar_out;
        send_ar(0, N_AR);
        wait_drain();
        check_eq("AR beats out", 64'(N_AR), 64'(ar_out - base));
        end_test();

        begin_test("r_pass", 0, 0, 1'b1);
        base = r_out;
        send_r(0, N_R);
        wait_drain();
        check_eq("R beats out", 64'(N_R), 64'(r_out - base));
        end_test();

        // N beats in N+1 cycles on each channel
        begin_test("throughput", 0, 0, 1'b1);
        start = cyc;
        fork
            send_ar(0, N_AR);
            send_r(0, N_R);
        join
        wait_drain();
        check_eq("AR cycles", 64'(N_AR + 1), 64'(ar_done - start));
        check_eq("R cycles", 64'(N_R + 1), 64'(r_done - start));
        end_test();

        begin_test("stall", 1, 0, 1'b0);
        base = ar_acc;
        fork
            send_ar(0, 3);
            begin
                repeat (10) begin
                    @(posedge clk);
                    #1;
                    if (ar_acc - base >= 2) begin
                        check_true(!s_axi_arready, "AR ready high with two beats held");
                    end
                end
                check_eq("AR beats held", 64'd2, 64'(ar_acc - base));
                @(negedge clk);
                ar_mode = 0;
            end
        join
        wait_drain();
        end_test();

        begin_test("random", 2, 2, 1'b0);
        base   = ar_out;
        base_r = r_out;
        fork
            send_ar(0, N_AR);
            send_r(0, N_R);
        join
        wait_drain();
        check_eq("AR beats out", 64'(N_AR), 64'(ar_out - base));
        check_eq("R beats out", 64'(N_R), 64'(r_out - base_r));
        end_test();

        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* rtl/tmr_axi_reg_rd.sv */
//*********************************************************************
// Triple-redundant AXI4 read register slice, AR and R channels.
// Both channels use a skid buffer; one cycle of latency each way.
// Inputs fan out to all copies and outputs are majority voted.
// No user, lock, cache, prot, QoS or region signals.
//*********************************************************************

`timescale 1ns/1ps

`include "axi_reg_defs.svh"

module tmr_axi_reg_rd (
    input  logic                          clk,
    input  logic                          rst_n,

    // Slave side towards the AXI master
    input  logic [`AXI_ID_W-1:0]          s_axi_arid,
    input  logic [`AXI_ADDR_W-1:0]        s_axi_araddr,
    input  logic [`AXI_LEN_W-1:0]         s_axi_arlen,
    input  logic [axi_reg_pkg::SIZE_W-1:0] s_axi_arsize,
    input  axi_reg_pkg::burst_t           s_axi_arburst,
    input  logic                          s_axi_arvalid,
    output logic                          s_axi_arready,
    output logic [`AXI_ID_W-1:0]          s_axi_rid,
    output logic [`AXI_DATA_W-1:0]        s_axi_rdata,
    output axi_reg_pkg::resp_t            s_axi_rresp,
    output logic                          s_axi_rlast,
    output logic                          s_axi_rvalid,
    input  logic                          s_axi_rready,

    // Master side towards the AXI slave
    output logic [`AXI_ID_W-1:0]          m_axi_arid,
    output logic [`AXI_ADDR_W-1:0]        m_axi_araddr,
    output logic [`AXI_LEN_W-1:0]         m_axi_arlen,
    output logic [axi_reg_pkg::SIZE_W-1:0] m_axi_arsize,
    output axi_reg_pkg::burst_t           m_axi_arburst,
    output logic                          m_axi_arvalid,
    input  logic                          m_axi_arready,
    input  logic [`AXI_ID_W-1:0]          m_axi_rid,
    input  logic [`AXI_DATA_W-1:0]        m_axi_rdata,
    input  axi_reg_pkg::resp_t            m_axi_rresp,
    input  logic                          m_axi_rlast,
    input  logic                          m_axi_rvalid,
    output logic                          m_axi_rready
);
    import axi_reg_pkg::*;

    ar_beat_t s_ar;
    r_beat_t  m_r;
    ar_beat_t m_ar_vote;
    r_beat_t  s_r_vote;

    // Incoming beats shared by all copies
    assign s_ar = '{
        id:    s_axi_arid,
        addr:  s_axi_araddr,
        len:   s_axi_arlen,
        size:  s_axi_arsize,
        burst: s_axi_arburst
    };

    assign m_r = '{
        id:   m_axi_rid,
        data: m_axi_rdata,
        resp: m_axi_rresp,
        last: m_axi_rlast
    };

    rd_rep_if rep_if [3] ();

    for (genvar i = 0; i < 3; i++) begin : g_copy
        axi_skid_buf #(
            .payload_t (ar_beat_t)
        ) u_ar_buf (
            .clk     (clk),
            .rst_n   (rst_n),
            .s_valid (s_axi_arvalid),
            .s_ready (rep_if[i].s_ar_ready),
            .s_data  (s_ar),
            .m_valid (rep_if[i].m_ar_valid),
            .m_ready (m_axi_arready),
            .m_data  (rep_if[i].m_ar)
        );

        // R flows from the m side back to the s side
        axi_skid_buf #(
            .payload_t (r_beat_t)
        ) u_r_buf (
            .clk     (clk),
            .rst_n   (rst_n),
            .s_valid (m_axi_rvalid),
            .s_ready (rep_if[i].m_r_ready),
            .s_data  (m_r),
            .m_valid (rep_if[i].s_r_valid),
            .m_ready (s_axi_rready),
            .m_data  (rep_if[i].s_r)
        );
    end

    tmr_rd_voter u_voter (
        .rep0          (rep_if[0]),
        .rep1          (rep_if[1]),
        .rep2          (rep_if[2]),
        .s_axi_arready (s_axi_arready),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_r           (s_r_vote),
        .m_axi_arvalid (m_axi_arvalid),
        .m_ar          (m_ar_vote),
        .m_axi_rready  (m_axi_rready)
    );

    // Voted beats back onto flat ports
    assign m_axi_arid    = m_ar_vote.id;
    assign m_axi_araddr  = m_ar_vote.addr;
    assign m_axi_arlen   = m_ar_vote.len;
    assign m_axi_arsize  = m_ar_vote.size;
    assign m_axi_arburst = m_ar_vote.burst;

    assign s_axi_rid     = s_r_vote.id;
    assign s_axi_rdata   = s_r_vote.data;
    assign s_axi_rresp   = s_r_vote.resp;
    assign s_axi_rlast   = s_r_vote.last;

endmodule

/* rtl/tmr_rd_voter.sv */
//*********************************************************************
// Bitwise two-of-three vote over the outputs of the three copies.
// Purely combinational. A single faulty copy is masked on every bit;
// disagreement is not reported.
//*********************************************************************

`timescale 1ns/1ps

module tmr_rd_voter (
    rd_rep_if.vote              rep0,
    rd_rep_if.vote              rep1,
    rd_rep_if.vote              rep2,
    output logic                s_axi_arready,
    output logic                s_axi_rvalid,
    output axi_reg_pkg::r_beat_t  s_r,
    output logic                m_axi_arvalid,
    output axi_reg_pkg::ar_beat_t m_ar,
    output logic                m_axi_rready
);

    // AR channel
    assign s_axi_arready = (rep0.s_ar_ready & rep1.s_ar_ready)
                         | (rep0.s_ar_ready & rep2.s_ar_ready)
                         | (rep1.s_ar_ready & rep2.s_ar_ready);

    assign m_axi_arvalid = (rep0.m_ar_valid & rep1.m_ar_valid)
                         | (rep0.m_ar_valid & rep2.m_ar_valid)
                         | (rep1.m_ar_valid & rep2.m_ar_valid);

    // Whole beat voted as one vector
    assign m_ar = (rep0.m_ar & rep1.m_ar)
                | (rep0.m_ar & rep2.m_ar)
                | (rep1.m_ar & rep2.m_ar);

    // R channel
    assign m_axi_rready = (rep0.m_r_ready & rep1.m_r_ready)
                        | (rep0.m_r_ready & rep2.m_r_ready)
                        | (rep1.m_r_ready & rep2.m_r_ready);

    assign s_axi_rvalid = (rep0.s_r_valid & rep1.s_r_valid)
                        | (rep0.s_r_valid & rep2.s_r_valid)
                        | (rep1.s_r_valid & rep2.s_r_valid);

    assign s_r = (rep0.s_r & rep1.s_r)
               | (rep0.s_r & rep2.s_r)
               | (rep1.s_r & rep2.s_r);

endmodule

/* rtl/axi_skid_buf.sv */
//*********************************************************************
// Two-entry valid/ready register slice. s_ready comes from a flop,
// so no combinational path runs from m_ready to s_ready.
// Payload registers have no reset; only the valid bits are cleared.
//*********************************************************************

`timescale 1ns/1ps

module axi_skid_buf #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     s_valid,
    output logic     s_ready,
    input  payload_t s_data,
    output logic     m_valid,
    input  logic     m_ready,
    output payload_t m_data
);

    logic     out_valid;
    logic     out_valid_nxt;
    payload_t out_data;
    logic     skid_valid;
    logic     skid_valid_nxt;
    payload_t skid_data;
    logic     s_ready_reg;
    logic     accept;
    logic     out_free;
    logic     load_out_in;
    logic     load_out_skid;
    logic     load_skid;

    assign accept   = s_valid && s_ready_reg;
    // Output register is empty or drains on this edge
    assign out_free = m_ready || !out_valid;

    always_comb begin
        out_valid_nxt  = out_valid;
        skid_valid_nxt = skid_valid;
        load_out_in    = 1'b0;
        load_out_skid  = 1'b0;
        load_skid      = 1'b0;
        if (out_free) begin
            if (skid_valid) begin
                // Older beat in skid goes first
                load_out_skid  = 1'b1;
                out_valid_nxt  = 1'b1;
                skid_valid_nxt = 1'b0;
            end else begin
                load_out_in   = accept;
                out_valid_nxt = accept;
            end
        end else if (accept) begin
            load_skid      = 1'b1;
            skid_valid_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            skid_valid  <= 1'b0;
            s_ready_reg <= 1'b0;
        end else begin
            out_valid   <= out_valid_nxt;
            skid_valid  <= skid_valid_nxt;
            s_ready_reg <= !skid_valid_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out_skid) begin
            out_data <= skid_data;
        end else if (load_out_in) begin
            out_data <= s_data;
        end
        if (load_skid) begin
            skid_data <= s_data;
        end
    end

    assign s_ready = s_ready_reg;
    assign m_valid = out_valid;
    assign m_data  = out_data;

endmodule

/* rtl/rd_rep_if.sv */
//*********************************************************************
// Outputs of one redundant copy of the read slice, as seen by the
// majority voter. One instance per copy.
//*********************************************************************

`timescale 1ns/1ps

interface rd_rep_if;
    import axi_reg_pkg::*;

    // AR channel
    logic     s_ar_ready;
    logic     m_ar_valid;
    ar_beat_t m_ar;

    // R channel
    logic     m_r_ready;
    logic     s_r_valid;
    r_beat_t  s_r;

    modport rep (
        output s_ar_ready, m_ar_valid, m_ar,
        output m_r_ready, s_r_valid, s_r
    );

    modport vote (
        input s_ar_ready, m_ar_valid, m_ar,
        input m_r_ready, s_r_valid, s_r
    );

endinterface

/* rtl/axi_reg_pkg.sv */
//*********************************************************************
// Beat types for the AR and R channels. Widths follow the macros in
// axi_reg_defs.svh. The reserved burst code 2'b11 has no name here.
//*********************************************************************

`include "axi_reg_defs.svh"

package axi_reg_pkg;

    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    typedef enum logic [BURST_W-1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_t;

    typedef enum logic [RESP_W-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_t;

    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [`AXI_LEN_W-1:0]  len;
        logic [SIZE_W-1:0]      size;
        burst_t                 burst;
    } ar_beat_t;

    // Read data beat
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        resp_t                  resp;
        logic                   last;
    } r_beat_t;

endpackage

/* rtl/axi_reg_defs.svh */
//*********************************************************************
// Field widths of the AXI read path. The size, burst and response
// widths are fixed by the protocol and live in the package.
//*********************************************************************

`ifndef AXI_REG_DEFS_SVH
`define AXI_REG_DEFS_SVH

// Transaction ID
`define AXI_ID_W 4

`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// AXI4 burst length of up to 256 beats
`define AXI_LEN_W 8

`endif
